/* msx_fdc_pkg.sv */
package msx_fdc_pkg;

   localparam logic [3:0] DEV_WD2793 = 4'd5;

   // Disk geometry.
   localparam int SECTOR_BYTES      = 512;
   localparam int SECTORS_PER_TRACK = 9;
   localparam int TRACKS            = 80;
   localparam int SINGLE_SIDED_MAX  = 368640;

   // Upper nibble of the command register.
   localparam logic [3:0] CMD_RESTORE   = 4'h0;
   localparam logic [3:0] CMD_SEEK      = 4'h1;
   localparam logic [3:0] CMD_READ      = 4'h8;
   localparam logic [3:0] CMD_WRITE     = 4'hA;
   localparam logic [3:0] CMD_FORCE_INT = 4'hD;

   typedef enum logic [1:0] {
      DRIVE_NONE,
      DRIVE_A,
      DRIVE_B
   } drive_t;

   typedef struct packed {
      logic [13:0] addr;
      logic [7:0]  data;
      logic        rd;
      logic        wr;
      logic        req;
      logic        mreq;
      logic        clk_en;
   } cpu_bus_t;

   typedef struct packed {
      logic [3:0] typ;
      logic [1:0] num;
      logic [7:0] param;
   } dev_sel_t;

   typedef struct packed {
      logic        mounted;
      logic        readonly;
      logic [31:0] size;
   } image_info_t;

   typedef struct packed {
      logic [31:0] lba;
      logic        rd;
      logic        wr;
   } sd_req_t;

   typedef struct packed {
      logic       ack;
      logic [8:0] buff_addr;
      logic [7:0] buff_data;
      logic       buff_wr;
   } sd_resp_t;

   typedef struct packed {
      logic not_ready;
      logic write_protect;
      logic head_loaded;
      logic seek_error;
      logic crc_error;
      logic track0;
      logic index;
      logic busy;
   } fdc_type1_t;

   typedef struct packed {
      logic not_ready;
      logic write_protect;
      logic record_type;
      logic rnf;
      logic crc_error;
      logic lost_data;
      logic drq;
      logic busy;
   } fdc_type2_t;

   // The status word is read through the view of the last command type.
   typedef union packed {
      fdc_type1_t t1;
      fdc_type2_t t2;
      logic [7:0] raw;
   } fdc_status_u;

endpackage

/* fdc_glue.sv */
`timescale 1ns/100ps

module fdc_glue
   import msx_fdc_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  cpu_bus_t    cpu_bus,
   input  dev_sel_t    dev,
   input  image_info_t image,
   input  logic [7:0]  reg_data,
   input  logic        drq,
   input  logic        intrq,
   output logic        wd_sel,
   output logic        ready,
   output logic        side,
   output logic        layout,
   output logic [7:0]  data,
   output logic        data_oe_rq
);

   logic [7:0] side_reg;
   logic [7:0] drive_reg;
   logic       motor;
   logic       image_mounted;
   drive_t     drive;

   wire cs            = (dev.typ == DEV_WD2793) && (dev.num == 2'd0);
   wire area_philips  = (cpu_bus.addr[13:3] == 11'h7FF) && (dev.param == 8'h00);
   wire area_national = (cpu_bus.addr[13:7] == 7'h7F) && (dev.param == 8'h01);
   wire device_cs     = cs && (area_philips || area_national) && cpu_bus.mreq;
   wire latch_wr      = device_cs && cpu_bus.wr && cpu_bus.req && cpu_bus.addr[2];

   assign wd_sel = device_cs && !cpu_bus.addr[2];
   assign ready  = image_mounted && motor && (drive == DRIVE_A);

   // Layout is 1 for a single-sided image.
   always_ff @(posedge clk) begin
      if (reset) begin
         image_mounted <= 1'b0;
         layout        <= 1'b0;
      end else if (image.mounted) begin
         image_mounted <= (image.size != 32'd0);
         layout        <= (image.size <= 32'(SINGLE_SIDED_MAX));
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         side_reg  <= 8'd0;
         drive_reg <= 8'd0;
         drive     <= DRIVE_A;
         side      <= 1'b0;
         motor     <= 1'b0;
      end else if (latch_wr) begin
         if (area_philips) begin
            if (cpu_bus.addr[1:0] == 2'd0) begin
               side_reg <= cpu_bus.data;
               side     <= cpu_bus.data[0];
            end
            if (cpu_bus.addr[1:0] == 2'd1) begin
               drive_reg <= cpu_bus.data;
               motor     <= cpu_bus.data[7];
               case (cpu_bus.data[1:0])
                  2'd0, 2'd2: drive <= DRIVE_A;
                  2'd1:       drive <= DRIVE_B;
                  default:    drive <= DRIVE_NONE;
               endcase
            end
         end else begin
            // National control register.
            case (cpu_bus.data[1:0])
               2'd1:    drive <= DRIVE_A;
               2'd2:    drive <= DRIVE_B;
               default: drive <= DRIVE_NONE;
            endcase
            side  <= cpu_bus.data[2];
            motor <= cpu_bus.data[3];
         end
      end
   end

   always_comb begin
      data       = 8'hFF;
      data_oe_rq = 1'b0;
      if (cpu_bus.rd && device_cs) begin
         if (!cpu_bus.addr[2]) begin
            data       = reg_data;
            data_oe_rq = 1'b1;
         end else if (area_philips) begin
            case (cpu_bus.addr[1:0])
               2'd0: begin
                  data       = side_reg;
                  data_oe_rq = 1'b1;
               end
               2'd1: begin
                  data       = drive_reg & 8'hFB;
                  data_oe_rq = 1'b1;
               end
               2'd3: begin
                  data       = {~drq, ~intrq, 6'h3F};
                  data_oe_rq = 1'b1;
               end
               default: ;
            endcase
         end else begin
            data       = {intrq, ~drq, 6'h3F};
            data_oe_rq = 1'b1;
         end
      end
   end

endmodule

/* wd_fdc_core.sv */
`timescale 1ns/100ps

module wd_fdc_core
   import msx_fdc_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  cpu_bus_t    cpu_bus,
   input  logic        wd_sel,
   input  logic        ready,
   input  logic        side,
   input  logic        layout,
   input  image_info_t image,
   input  sd_resp_t    sd_resp,
   input  logic [7:0]  buf_rdata,
   output logic [7:0]  reg_data,
   output logic        drq,
   output logic        intrq,
   output sd_req_t     sd_req,
   output logic [8:0]  buf_addr,
   output logic [7:0]  buf_wdata,
   output logic        buf_we
);

   typedef enum logic [3:0] {
      S_IDLE, S_SEEK, S_SETTLE, S_DONE,
      S_RD_REQ, S_RD_FETCH, S_RD_LOAD, S_RD_WAIT,
      S_WR_WAIT, S_WR_STORE, S_WR_REQ
   } state_t;

   state_t      state;
   logic [7:0]  cmd_reg;
   logic [7:0]  track_reg;
   logic [7:0]  sector_reg;
   logic [7:0]  data_reg;
   logic [7:0]  target;
   logic        busy;
   logic        cmd_pend;
   logic        fi_pend;
   logic        last_type2;
   logic        nr_flag;
   logic        wp_flag;
   logic        rnf_flag;
   logic        seek_err;
   logic        ack_seen;
   logic [1:0]  settle_cnt;
   logic [8:0]  byte_cnt;
   logic [31:0] trk_side;
   logic [31:0] lba_calc;
   fdc_status_u status;

   wire reg_wr     = wd_sel && cpu_bus.wr && cpu_bus.req;
   wire reg_rd     = wd_sel && cpu_bus.rd && cpu_bus.req;
   wire stat_rd    = reg_rd && (cpu_bus.addr[1:0] == 2'd0);
   wire data_rd    = reg_rd && (cpu_bus.addr[1:0] == 2'd3);
   wire data_wr    = reg_wr && (cpu_bus.addr[1:0] == 2'd3);
   wire last_byte  = (byte_cnt == 9'(SECTOR_BYTES - 1));
   wire is_write   = (cmd_reg[7:4] == CMD_WRITE);
   wire wp_hit     = is_write && image.readonly;
   wire sector_bad = (sector_reg == 8'd0) || (sector_reg > 8'(SECTORS_PER_TRACK));

   // Double-sided images interleave the two sides of each track.
   always_comb begin
      if (layout) begin
         trk_side = {24'd0, track_reg};
      end else begin
         trk_side = {23'd0, track_reg, side};
      end
      lba_calc = trk_side * SECTORS_PER_TRACK + {24'd0, sector_reg} - 32'd1;
   end

   always_comb begin
      status = '0;
      if (last_type2) begin
         status.t2.not_ready     = nr_flag;
         status.t2.write_protect = wp_flag;
         status.t2.rnf           = rnf_flag;
         status.t2.drq           = drq;
         status.t2.busy          = busy;
      end else begin
         status.t1.not_ready     = !ready;
         status.t1.write_protect = image.readonly;
         status.t1.head_loaded   = ready;
         status.t1.seek_error    = seek_err;
         status.t1.track0        = (track_reg == 8'd0);
         status.t1.busy          = busy;
      end
   end

   always_comb begin
      case (cpu_bus.addr[1:0])
         2'd0:    reg_data = status.raw;
         2'd1:    reg_data = track_reg;
         2'd2:    reg_data = sector_reg;
         default: reg_data = data_reg;
      endcase
   end

   assign buf_addr  = byte_cnt;
   assign buf_wdata = data_reg;
   assign buf_we    = (state == S_WR_STORE);

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= S_IDLE;
         busy       <= 1'b0;
         drq        <= 1'b0;
         intrq      <= 1'b0;
         cmd_pend   <= 1'b0;
         fi_pend    <= 1'b0;
         last_type2 <= 1'b0;
         nr_flag    <= 1'b0;
         wp_flag    <= 1'b0;
         rnf_flag   <= 1'b0;
         seek_err   <= 1'b0;
         ack_seen   <= 1'b0;
         track_reg  <= 8'd0;
         sector_reg <= 8'd1;
         sd_req.rd  <= 1'b0;
         sd_req.wr  <= 1'b0;
      end else begin
         if (reg_wr) begin
            case (cpu_bus.addr[1:0])
               2'd0: begin
                  if (cpu_bus.data[7:4] == CMD_FORCE_INT) begin
                     fi_pend <= 1'b1;
                  end else if (!busy) begin
                     cmd_reg  <= cpu_bus.data;
                     cmd_pend <= 1'b1;
                     intrq    <= 1'b0;
                  end
               end
               2'd1:    track_reg  <= cpu_bus.data;
               2'd2:    sector_reg <= cpu_bus.data;
               default: data_reg   <= cpu_bus.data;
            endcase
         end
         if (stat_rd) begin
            intrq <= 1'b0;
         end

         case (state)
            S_IDLE: begin
               if (cmd_pend && cpu_bus.clk_en) begin
                  cmd_pend <= 1'b0;
                  busy     <= 1'b1;
                  case (cmd_reg[7:4])
                     CMD_RESTORE: begin
                        last_type2 <= 1'b0;
                        seek_err   <= 1'b0;
                        target     <= 8'd0;
                        state      <= S_SEEK;
                     end
                     CMD_SEEK: begin
                        last_type2 <= 1'b0;
                        seek_err   <= (data_reg >= 8'(TRACKS));
                        target     <= (data_reg >= 8'(TRACKS)) ? 8'(TRACKS - 1) : data_reg;
                        state      <= S_SEEK;
                     end
                     CMD_READ, CMD_WRITE: begin
                        last_type2 <= 1'b1;
                        nr_flag    <= !ready;
                        wp_flag    <= wp_hit;
                        rnf_flag   <= sector_bad;
                        byte_cnt   <= 9'd0;
                        ack_seen   <= 1'b0;
                        sd_req.lba <= lba_calc;
                        if (!ready || wp_hit || sector_bad) begin
                           state <= S_DONE;
                        end else if (is_write) begin
                           drq   <= 1'b1;
                           state <= S_WR_WAIT;
                        end else begin
                           sd_req.rd <= 1'b1;
                           state     <= S_RD_REQ;
                        end
                     end
                     default: state <= S_DONE;
                  endcase
               end
            end
            S_SEEK: begin
               if (cpu_bus.clk_en) begin
                  if (track_reg == target) begin
                     settle_cnt <= 2'd0;
                     state      <= S_SETTLE;
                  end else if (track_reg < target) begin
                     track_reg <= track_reg + 8'd1;
                  end else begin
                     track_reg <= track_reg - 8'd1;
                  end
               end
            end
            S_SETTLE: begin
               settle_cnt <= settle_cnt + 2'd1;
               if (settle_cnt == 2'd3) begin
                  busy  <= 1'b0;
                  intrq <= 1'b1;
                  state <= S_IDLE;
               end
            end
            S_DONE: begin
               busy  <= 1'b0;
               intrq <= 1'b1;
               state <= S_IDLE;
            end
            // Second ack closes the store transfer.
            S_RD_REQ: begin
               if (sd_resp.ack) begin
                  if (ack_seen) begin
                     sd_req.rd <= 1'b0;
                     state     <= S_RD_FETCH;
                  end else begin
                     ack_seen <= 1'b1;
                  end
               end
            end
            S_RD_FETCH: state <= S_RD_LOAD;
            S_RD_LOAD: begin
               data_reg <= buf_rdata;
               drq      <= 1'b1;
               state    <= S_RD_WAIT;
            end
            S_RD_WAIT: begin
               if (data_rd) begin
                  drq <= 1'b0;
                  if (last_byte) begin
                     state <= S_DONE;
                  end else begin
                     byte_cnt <= byte_cnt + 9'd1;
                     state    <= S_RD_FETCH;
                  end
               end
            end
            S_WR_WAIT: begin
               if (data_wr) begin
                  drq   <= 1'b0;
                  state <= S_WR_STORE;
               end
            end
            S_WR_STORE: begin
               if (last_byte) begin
                  sd_req.wr <= 1'b1;
                  state     <= S_WR_REQ;
               end else begin
                  byte_cnt <= byte_cnt + 9'd1;
                  drq      <= 1'b1;
                  state    <= S_WR_WAIT;
               end
            end
            S_WR_REQ: begin
               if (sd_resp.ack) begin
                  if (ack_seen) begin
                     sd_req.wr <= 1'b0;
                     state     <= S_DONE;
                  end else begin
                     ack_seen <= 1'b1;
                  end
               end
            end
            default: state <= S_IDLE;
         endcase

         // Force Interrupt overrides whatever the FSM did this cycle.
         if (fi_pend && cpu_bus.clk_en) begin
            fi_pend   <= 1'b0;
            cmd_pend  <= 1'b0;
            busy      <= 1'b0;
            drq       <= 1'b0;
            intrq     <= 1'b1;
            sd_req.rd <= 1'b0;
            sd_req.wr <= 1'b0;
            state     <= S_IDLE;
            if (!busy) begin
               last_type2 <= 1'b0;
            end
         end
      end
   end

endmodule

/* sector_buffer.sv */
`timescale 1ns/100ps

module sector_buffer
   import msx_fdc_pkg::*;
(
   input  logic       clk,
   input  logic [8:0] a_addr,
   input  logic [7:0] a_wdata,
   input  logic       a_we,
   input  logic [8:0] b_addr,
   input  logic [7:0] b_wdata,
   input  logic       b_we,
   output logic [7:0] a_rdata,
   output logic [7:0] b_rdata
);

   logic [7:0] mem [SECTOR_BYTES];

   // Port A belongs to the core, port B to the image store.
   // Their accesses never overlap in time.
   always_ff @(posedge clk) begin
      if (a_we) begin
         mem[a_addr] <= a_wdata;
      end
      if (b_we) begin
         mem[b_addr] <= b_wdata;
      end
      a_rdata <= mem[a_addr];
      b_rdata <= mem[b_addr];
   end

endmodule

/* msx_fdc_top.sv */
`timescale 1ns/100ps

module msx_fdc_top
   import msx_fdc_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  cpu_bus_t    cpu_bus,
   input  dev_sel_t    dev,
   input  image_info_t image,
   input  sd_resp_t    sd_resp,
   output logic [7:0]  data,
   output logic        data_oe_rq,
   output sd_req_t     sd_req,
   output logic [7:0]  sd_buff_data
);

   logic       wd_sel;
   logic       ready;
   logic       side;
   logic       layout;
   logic [7:0] reg_data;
   logic       drq;
   logic       intrq;
   logic [8:0] buf_addr;
   logic [7:0] buf_wdata;
   logic [7:0] buf_rdata;
   logic       buf_we;

   fdc_glue fdc_glue_i (
      .clk        (clk),
      .reset      (reset),
      .cpu_bus    (cpu_bus),
      .dev        (dev),
      .image      (image),
      .reg_data   (reg_data),
      .drq        (drq),
      .intrq      (intrq),
      .wd_sel     (wd_sel),
      .ready      (ready),
      .side       (side),
      .layout     (layout),
      .data       (data),
      .data_oe_rq (data_oe_rq)
   );

   wd_fdc_core wd_fdc_core_i (
      .clk       (clk),
      .reset     (reset),
      .cpu_bus   (cpu_bus),
      .wd_sel    (wd_sel),
      .ready     (ready),
      .side      (side),
      .layout    (layout),
      .image     (image),
      .sd_resp   (sd_resp),
      .buf_rdata (buf_rdata),
      .reg_data  (reg_data),
      .drq       (drq),
      .intrq     (intrq),
      .sd_req    (sd_req),
      .buf_addr  (buf_addr),
      .buf_wdata (buf_wdata),
      .buf_we    (buf_we)
   );

   sector_buffer sector_buffer_i (
      .clk     (clk),
      .a_addr  (buf_addr),
      .a_wdata (buf_wdata),
      .a_we    (buf_we),
      .b_addr  (sd_resp.buff_addr),
      .b_wdata (sd_resp.buff_data),
      .b_we    (sd_resp.buff_wr),
      .a_rdata (buf_rdata),
      .b_rdata (sd_buff_data)
   );

endmodule

/* tb_disk_model.sv */
`timescale 1ns/100ps

module tb_disk_model
   import msx_fdc_pkg::*;
(
   input  logic       clk,
   input  sd_req_t    sd_req,
   input  logic [7:0] sd_buff_data,
   output sd_resp_t   sd_resp
);

   localparam int IMAGE_BYTES = 737280;

   logic [7:0] mem [IMAGE_BYTES];
   int         base;

   // Each request level gets one ack, 512 byte steps and a closing ack.
   initial begin
      sd_resp <= '0;
      forever begin
         @(posedge clk);
         if (sd_req.rd || sd_req.wr) begin
            base = int'(sd_req.lba) * SECTOR_BYTES;
            sd_resp.ack <= 1'b1;
            @(posedge clk);
            sd_resp.ack <= 1'b0;
            if (sd_req.rd) begin
               for (int i = 0; i < SECTOR_BYTES; i++) begin
                  sd_resp.buff_addr <= 9'(i);
                  sd_resp.buff_data <= mem[base + i];
                  sd_resp.buff_wr   <= 1'b1;
                  @(posedge clk);
               end
               sd_resp.buff_wr <= 1'b0;
            end else begin
               // Buffer read data trails the presented address by two edges.
               for (int i = 0; i < SECTOR_BYTES + 2; i++) begin
                  if (i < SECTOR_BYTES) begin
                     sd_resp.buff_addr <= 9'(i);
                  end
                  if (i >= 2) begin
                     mem[base + i - 2] = sd_buff_data;
                  end
                  @(posedge clk);
               end
            end
            sd_resp.ack <= 1'b1;
            @(posedge clk);
            sd_resp.ack <= 1'b0;
         end
      end
   end

endmodule

/* tb_msx_fdc.sv */
`timescale 1ns/100ps

module tb_msx_fdc
   import msx_fdc_pkg::*;
();

   localparam logic [13:0] PH_CMD    = 14'h3FF8;
   localparam logic [13:0] PH_TRACK  = 14'h3FF9;
   localparam logic [13:0] PH_SECTOR = 14'h3FFA;
   localparam logic [13:0] PH_DATA   = 14'h3FFB;
   localparam logic [13:0] PH_SIDE   = 14'h3FFC;
   localparam logic [13:0] PH_DRIVE  = 14'h3FFD;
   localparam logic [13:0] PH_FLAGS  = 14'h3FFF;
   localparam logic [13:0] NA_CMD    = 14'h3F80;
   localparam logic [13:0] NA_TRACK  = 14'h3F81;
   localparam logic [13:0] NA_CTRL   = 14'h3F84;
   localparam int          POLL_LIMIT  = 2000;
   localparam int          IMAGE_BYTES = 737280;

   logic        clk;
   logic        reset;
   cpu_bus_t    cpu_bus;
   dev_sel_t    dev;
   image_info_t image;
   sd_resp_t    sd_resp;
   logic [7:0]  data;
   logic        data_oe_rq;
   sd_req_t     sd_req;
   logic [7:0]  sd_buff_data;

   int seed = 51232;
   int errors = 0;
   int test_errors = 0;
   int tests = 0;
   int failed_tests = 0;
   int store_cycles = 0;
   bit aborted = 1'b0;

   msx_fdc_top msx_fdc_top_i (
      .clk          (clk),
      .reset        (reset),
      .cpu_bus      (cpu_bus),
      .dev          (dev),
      .image        (image),
      .sd_resp      (sd_resp),
      .data         (data),
      .data_oe_rq   (data_oe_rq),
      .sd_req       (sd_req),
      .sd_buff_data (sd_buff_data)
   );

   tb_disk_model disk_model_i (
      .clk          (clk),
      .sd_req       (sd_req),
      .sd_buff_data (sd_buff_data),
      .sd_resp      (sd_resp)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      if (sd_req.rd || sd_req.wr) begin
         store_cycles <= store_cycles + 1;
      end
   end

   function automatic logic [7:0] image_byte(input int lba, input int offset);
      int sum;
      sum = lba * 7 + offset;
      return sum[7:0] ^ 8'h5A;
   endfunction

   function automatic int block_address(input int track, input int side, input int sector,
                                        input bit single_sided);
      if (single_sided) begin
         return track * SECTORS_PER_TRACK + sector - 1;
      end
      return (track * 2 + side) * SECTORS_PER_TRACK + sector - 1;
   endfunction

   function automatic logic [7:0] philips_flags(input logic drq_bit, input logic intrq_bit);
      return {~drq_bit, ~intrq_bit, 6'h3F};
   endfunction

   function automatic logic [7:0] national_flags(input logic drq_bit, input logic intrq_bit);
      return {intrq_bit, ~drq_bit, 6'h3F};
   endfunction

   function automatic cpu_bus_t bus_access(input logic [13:0] addr, input logic [7:0] value,
                                           input logic rd, input logic wr, input logic req);
      return '{addr: addr, data: value, rd: rd, wr: wr, req: req, mreq: req, clk_en: 1'b1};
   endfunction

   task automatic write_reg(input logic [13:0] addr, input logic [7:0] value);
      @(posedge clk);
      cpu_bus <= bus_access(addr, value, 1'b0, 1'b1, 1'b1);
      @(posedge clk);
      cpu_bus <= bus_access(14'h0000, 8'h00, 1'b0, 1'b0, 1'b0);
   endtask

   // Combinational read data is sampled half a cycle in.
   task automatic read_reg(input logic [13:0] addr, output logic [7:0] value, output logic oe);
      @(posedge clk);
      cpu_bus <= bus_access(addr, 8'h00, 1'b1, 1'b0, 1'b1);
      @(negedge clk);
      value = data;
      oe = data_oe_rq;
      @(posedge clk);
      cpu_bus <= bus_access(14'h0000, 8'h00, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic compare(input string name, input logic [7:0] expected,
                          input logic [7:0] actual);
      if (expected !== actual) begin
         $display("[ERROR] %s expected 0x%02h actual 0x%02h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic wait_bit(input logic [13:0] addr, input int bit_idx, input logic level,
                           input string what);
      logic [7:0] value;
      logic       oe;
      int         polls;
      if (!aborted) begin
         read_reg(addr, value, oe);
         polls = 1;
         while (value[bit_idx] !== level && polls < POLL_LIMIT) begin
            read_reg(addr, value, oe);
            polls++;
         end
         if (value[bit_idx] !== level) begin
            $display("Timeout: %s did not show up within %0d polls", what, POLL_LIMIT);
            errors++;
            aborted = 1'b1;
         end
      end
   endtask

   task automatic mount_image(input logic [31:0] size, input logic readonly);
      @(posedge clk);
      image <= '{mounted: 1'b1, readonly: readonly, size: size};
      @(posedge clk);
      image.mounted <= 1'b0;
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == test_errors) begin
         $display("test %s: ok", name);
      end else begin
         failed_tests++;
         $display("test %s: %0d error(s)", name, errors - test_errors);
      end
      test_errors = errors;
   endtask

   task automatic select_location(output int track, output int side, output int sector);
      track  = $unsigned($random(seed)) % TRACKS;
      side   = $unsigned($random(seed)) % 2;
      sector = $unsigned($random(seed)) % SECTORS_PER_TRACK + 1;
      write_reg(PH_SIDE, 8'(side));
      write_reg(PH_DRIVE, 8'h80);
      write_reg(PH_TRACK, 8'(track));
      write_reg(PH_SECTOR, 8'(sector));
   endtask

   task automatic reset_state_test();
      logic [7:0] value;
      logic       oe;
      read_reg(14'h1000, value, oe);
      compare("data_oe_rq", 8'h00, {7'd0, oe});
      compare("data", 8'hFF, value);
      read_reg(PH_FLAGS, value, oe);
      compare("philips flags", philips_flags(1'b0, 1'b0), value);
      read_reg(PH_TRACK, value, oe);
      compare("track", 8'h00, value);
      read_reg(PH_SECTOR, value, oe);
      compare("sector", 8'h01, value);
   endtask

   task automatic latch_test();
      logic [7:0] value;
      logic       oe;
      write_reg(PH_SIDE, 8'h01);
      read_reg(PH_SIDE, value, oe);
      compare("side latch", 8'h01, value);
      write_reg(PH_DRIVE, 8'h86);
      read_reg(PH_DRIVE, value, oe);
      compare("drive latch", 8'h86 & ~8'h04, value);
      @(posedge clk);
      dev <= '{typ: DEV_WD2793, num: 2'd1, param: 8'h00};
      read_reg(PH_DRIVE, value, oe);
      compare("data_oe_rq", 8'h00, {7'd0, oe});
      @(posedge clk);
      dev <= '{typ: DEV_WD2793, num: 2'd0, param: 8'h00};
   endtask

   task automatic national_test();
      logic [7:0] value;
      logic       oe;
      @(posedge clk);
      dev <= '{typ: DEV_WD2793, num: 2'd0, param: 8'h01};
      read_reg(NA_CTRL, value, oe);
      compare("national flags", national_flags(1'b0, 1'b0), value);
      read_reg(NA_TRACK, value, oe);
      compare("track", 8'h00, value);
      compare("data_oe_rq", 8'h01, {7'd0, oe});
      read_reg(14'h3F7F, value, oe);
      compare("data_oe_rq", 8'h00, {7'd0, oe});
      write_reg(NA_CMD, {CMD_FORCE_INT, 4'h0});
      wait_bit(NA_CTRL, 7, 1'b1, "intrq after Force Interrupt");
      read_reg(NA_CTRL, value, oe);
      compare("national flags", national_flags(1'b0, 1'b1), value);
      read_reg(NA_CMD, value, oe);
      read_reg(NA_CTRL, value, oe);
      compare("national flags", national_flags(1'b0, 1'b0), value);
      @(posedge clk);
      dev <= '{typ: DEV_WD2793, num: 2'd0, param: 8'h00};
   endtask

   task automatic seek_test();
      logic [7:0] value;
      logic       oe;
      int         target;
      write_reg(PH_TRACK, 8'h25);
      write_reg(PH_CMD, {CMD_RESTORE, 4'h0});
      wait_bit(PH_FLAGS, 6, 1'b0, "intrq after Restore");
      read_reg(PH_CMD, value, oe);
      compare("status", 8'h04, value & 8'h05);
      read_reg(PH_TRACK, value, oe);
      compare("track", 8'h00, value);
      target = $unsigned($random(seed)) % TRACKS;
      write_reg(PH_DATA, 8'(target));
      write_reg(PH_CMD, {CMD_SEEK, 4'h0});
      wait_bit(PH_FLAGS, 6, 1'b0, "intrq after Seek");
      read_reg(PH_CMD, value, oe);
      compare("status", (target == 0) ? 8'h04 : 8'h00, value & 8'h05);
      read_reg(PH_TRACK, value, oe);
      compare("track", 8'(target), value);
   endtask

   task automatic read_sector_test(input logic [31:0] size);
      logic [7:0] value;
      logic       oe;
      int         track;
      int         side;
      int         sector;
      int         lba;
      mount_image(size, 1'b0);
      select_location(track, side, sector);
      lba = block_address(track, side, sector, size <= SINGLE_SIDED_MAX);
      write_reg(PH_CMD, {CMD_READ, 4'h0});
      for (int i = 0; i < SECTOR_BYTES && !aborted; i++) begin
         wait_bit(PH_FLAGS, 7, 1'b0, "drq during Read Sector");
         read_reg(PH_DATA, value, oe);
         compare($sformatf("data[%0d]", i), image_byte(lba, i), value);
      end
      wait_bit(PH_FLAGS, 6, 1'b0, "intrq after Read Sector");
      read_reg(PH_CMD, value, oe);
      compare("status", 8'h00, value);
   endtask

   task automatic write_sector_test();
      logic [7:0] wbytes [SECTOR_BYTES];
      logic [7:0] value;
      logic       oe;
      int         track;
      int         side;
      int         sector;
      int         lba;
      for (int i = 0; i < SECTOR_BYTES; i++) begin
         wbytes[i] = 8'($random(seed));
      end
      mount_image(32'(IMAGE_BYTES), 1'b0);
      select_location(track, side, sector);
      lba = block_address(track, side, sector, 1'b0);
      write_reg(PH_CMD, {CMD_WRITE, 4'h0});
      for (int i = 0; i < SECTOR_BYTES && !aborted; i++) begin
         wait_bit(PH_FLAGS, 7, 1'b0, "drq during Write Sector");
         write_reg(PH_DATA, wbytes[i]);
      end
      wait_bit(PH_FLAGS, 6, 1'b0, "intrq after Write Sector");
      read_reg(PH_CMD, value, oe);
      compare("status", 8'h00, value);
      for (int i = 0; i < SECTOR_BYTES; i++) begin
         compare($sformatf("disk[%0d]", lba * SECTOR_BYTES + i), wbytes[i],
                 disk_model_i.mem[lba * SECTOR_BYTES + i]);
      end
   endtask

   task automatic refused_test(input logic [7:0] drive, input logic [7:0] command,
                               input logic [7:0] expected);
      logic [7:0] value;
      logic       oe;
      int         cycles_before;
      write_reg(PH_DRIVE, drive);
      cycles_before = store_cycles;
      write_reg(PH_CMD, command);
      wait_bit(PH_FLAGS, 6, 1'b0, "intrq after a refused command");
      read_reg(PH_CMD, value, oe);
      compare("status", expected, value);
      if (store_cycles != cycles_before) begin
         $display("A store request was made for a command that should have been refused");
         errors++;
      end
   endtask

   initial begin
      reset   <= 1'b1;
      cpu_bus <= bus_access(14'h0000, 8'h00, 1'b0, 1'b0, 1'b0);
      dev     <= '{typ: DEV_WD2793, num: 2'd0, param: 8'h00};
      image   <= '0;
      for (int i = 0; i < IMAGE_BYTES; i++) begin
         disk_model_i.mem[i] = image_byte(i / SECTOR_BYTES, i % SECTOR_BYTES);
      end
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      reset_state_test();
      end_test("reset state");
      latch_test();
      end_test("philips latches");
      national_test();
      end_test("national layout");
      seek_test();
      end_test("restore and seek");
      read_sector_test(32'(SINGLE_SIDED_MAX));
      end_test("read sector, single-sided");
      read_sector_test(32'(IMAGE_BYTES));
      end_test("read sector, double-sided");
      write_sector_test();
      end_test("write sector");
      // Motor off keeps drive A selected but not ready.
      refused_test(8'h00, {CMD_READ, 4'h0}, 8'h80);
      end_test("not ready");
      mount_image(32'(IMAGE_BYTES), 1'b1);
      refused_test(8'h80, {CMD_WRITE, 4'h0}, 8'h40);
      end_test("write protect");
      $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* sources.f */
msx_fdc_pkg.sv
fdc_glue.sv
wd_fdc_core.sv
sector_buffer.sv
msx_fdc_top.sv
tb_disk_model.sv
tb_msx_fdc.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_msx_fdc
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing
PASS_TEXT ?= TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
